//--- audio_pkg.sv
`include "spectrum_macros.svh"

package audio_pkg;

    // Raw microphone sample, offset binary, 128 is silence
    typedef logic [7:0] mic_sample_t;

    // Sample with the offset removed
    // Also holds the product with a +1/-1 reference
    typedef logic signed [8:0] centered_t;

    // I or Q sum over one window, 1024 x 128 fits with margin
    typedef logic signed [19:0] accum_t;

    // Bar height in rows, 0 .. SCREEN_HEIGHT
    typedef logic [$clog2(`SCREEN_HEIGHT + 1)-1:0] level_t;

    // Samples per half period of a band reference
    typedef logic [7:0] period_t;

    // Four-phase receiver states
    typedef enum logic [1:0] {
        idle,           // Ack low, waiting for request
        hold,           // Sample just taken, strobe out
        wait_release    // Ack high until request drops
    } capture_state_t;

endpackage

//--- band_converter.sv
`timescale 1ns/1ps
`include "spectrum_macros.svh"

module band_converter #(
    parameter int band_freq = 440
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sample_valid,
    input  audio_pkg::centered_t sample_data,
    output audio_pkg::level_t    level
);
    import audio_pkg::*;

    // Half period in samples, rounded to nearest
    localparam period_t half_period =
        period_t'((`SAMPLE_RATE_HZ + band_freq) / (2 * band_freq));
    localparam period_t quarter_period = period_t'(half_period >> 1);
    localparam period_t last_phase     = period_t'(2 * half_period - 1);
    localparam period_t q_neg_start    = period_t'(quarter_period + half_period);

    localparam int w_window  = $clog2(`WINDOW_LEN);
    localparam int w_acc     = $bits(accum_t);
    localparam int mag_shift = 8;

    period_t             phase;         // Position inside one full period
    logic [w_window-1:0] sample_cnt;
    accum_t              acc_i;
    accum_t              acc_q;
    logic                ref_i_neg;
    logic                ref_q_neg;
    centered_t           prod_i;
    centered_t           prod_q;
    accum_t              sum_i;
    accum_t              sum_q;
    logic                last_sample;

    logic [w_acc-1:0]         mag_i;
    logic [w_acc-1:0]         mag_q;
    logic                     stage1_valid;
    logic [w_acc:0]           est;
    logic                     stage2_valid;
    logic [w_acc-mag_shift:0] est_scaled;

    // ----------------------------------------
    // Quadrature mixer
    // ----------------------------------------
    assign ref_i_neg = (phase >= half_period);
    assign ref_q_neg = (phase < quarter_period) || (phase >= q_neg_start);  // I delayed by 1/4

    assign prod_i = ref_i_neg ? -sample_data : sample_data;
    assign prod_q = ref_q_neg ? -sample_data : sample_data;

    assign sum_i = acc_i + accum_t'(prod_i);    // Sign extended
    assign sum_q = acc_q + accum_t'(prod_q);

    assign last_sample = sample_valid && (sample_cnt == w_window'(`WINDOW_LEN - 1));

    // ----------------------------------------
    // Window integrator
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase        <= '0;
            sample_cnt   <= '0;
            acc_i        <= '0;
            acc_q        <= '0;
            stage1_valid <= 1'b0;
            stage2_valid <= 1'b0;
        end else begin
            stage1_valid <= last_sample;
            stage2_valid <= stage1_valid;
            if (last_sample) begin
                // Final sums go to the magnitude pipeline, next window starts clean
                phase      <= '0;
                sample_cnt <= '0;
                acc_i      <= '0;
                acc_q      <= '0;
            end else if (sample_valid) begin
                phase      <= (phase == last_phase) ? '0 : phase + 1'b1;
                sample_cnt <= sample_cnt + 1'b1;
                acc_i      <= sum_i;
                acc_q      <= sum_q;
            end
        end
    end

    // ----------------------------------------
    // Magnitude estimate, max + min/2
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (last_sample) begin
            mag_i <= sum_i[w_acc-1] ? -sum_i : sum_i;
            mag_q <= sum_q[w_acc-1] ? -sum_q : sum_q;
        end
        if (stage1_valid) begin
            est <= (mag_i >= mag_q) ? {1'b0, mag_i} + (mag_q >> 1)
                                    : {1'b0, mag_q} + (mag_i >> 1);
        end
    end

    assign est_scaled = est[w_acc:mag_shift];

    // Clip to screen height
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            level <= '0;
        end else if (stage2_valid) begin
            level <= (est_scaled > `SCREEN_HEIGHT) ? level_t'(`SCREEN_HEIGHT)
                                                   : level_t'(est_scaled);
        end
    end

endmodule

//--- bar_renderer.sv
`timescale 1ns/1ps
`include "spectrum_macros.svh"

module bar_renderer (
    input  logic                               clk,
    input  logic                               rst,
    input  video_pkg::coord_x_t                x,
    input  video_pkg::coord_y_t                y,
    input  audio_pkg::level_t [`NUM_BANDS-1:0] levels,
    output logic                               white
);
    import audio_pkg::*;
    import video_pkg::*;

    localparam int w_band = $clog2(`NUM_BANDS);

    column_t           column;
    logic [w_band-1:0] band_idx;
    logic              owned;
    level_t            band_level;
    coord_y_t          top_row;

    assign column = column_t'(x >> 4);  // 16-pixel columns

    // ----------------------------------------
    // Column decode
    // ----------------------------------------
    // Band b owns columns 3b+2 and 3b+3, one blank column between bars
    always_comb begin
        owned    = 1'b0;
        band_idx = '0;
        for (int b = 0; b < `NUM_BANDS; b++) begin
            if (column == column_t'(3 * b + 2) || column == column_t'(3 * b + 3)) begin
                owned    = 1'b1;
                band_idx = w_band'(b);
            end
        end
    end

    assign band_level = owned ? levels[band_idx] : '0;

    // First lit row of the bar, level never exceeds screen height
    assign top_row = coord_y_t'(`SCREEN_HEIGHT - band_level);

    // ----------------------------------------
    // Pixel output
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            white <= 1'b0;
        end else begin
            white <= owned && (y >= top_row);  // Bars grow up from the bottom
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --assert -Wno-fatal --top-module tb_spectrum -f verilog.f \
    -o sim_spectrum > build.log 2>&1 \
    && ./obj_dir/sim_spectrum > sim.log 2>&1

grep -q "^Simulation passed$" sim.log 2>/dev/null \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail, see build.log and sim.log"; exit 1; }

//--- sample_capture.sv
`timescale 1ns/1ps

module sample_capture (
    input  logic                   clk,
    input  logic                   rst,
    input  audio_pkg::mic_sample_t mic,
    input  logic                   mic_req,
    output logic                   mic_ack,
    output logic                   sample_valid,
    output audio_pkg::centered_t   sample_data
);
    import audio_pkg::*;

    capture_state_t state;
    capture_state_t state_next;

    // ----------------------------------------
    // Four-phase handshake FSM
    // ----------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (mic_req) begin
                    state_next = hold;
                end
            end
            hold: begin
                // Hold lasts one cycle, so the strobe does too
                state_next = mic_req ? wait_release : idle;
            end
            wait_release: begin
                if (!mic_req) begin
                    state_next = idle;
                end
            end
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    assign mic_ack      = (state != idle);  // Straight from the state register
    assign sample_valid = (state == hold);

    // Take the sample on entry to hold
    always_ff @(posedge clk) begin
        if (state == idle && mic_req) begin
            sample_data <= $signed({1'b0, mic}) - 9'sd128;  // Remove offset
        end
    end

endmodule

//--- spectrum.sv
`timescale 1ns/1ps
`include "spectrum_macros.svh"

module spectrum (
    input  logic                   clk,
    input  logic                   rst,
    input  video_pkg::coord_x_t    x,
    input  video_pkg::coord_y_t    y,
    input  audio_pkg::mic_sample_t mic,
    input  logic                   mic_req,
    output logic                   mic_ack,
    output video_pkg::color_t      red,
    output video_pkg::color_t      green,
    output video_pkg::color_t      blue
);
    import audio_pkg::*;

    // Band centre frequencies, lowest first
    localparam int band_freq_table [`NUM_BANDS] = '{
        `BAND_FREQ_0, `BAND_FREQ_1, `BAND_FREQ_2,  `BAND_FREQ_3,
        `BAND_FREQ_4, `BAND_FREQ_5, `BAND_FREQ_6,  `BAND_FREQ_7,
        `BAND_FREQ_8, `BAND_FREQ_9, `BAND_FREQ_10, `BAND_FREQ_11
    };

    logic                    sample_valid;
    centered_t               sample_data;
    level_t [`NUM_BANDS-1:0] levels;
    logic                    white;

    // ----------------------------------------
    // Audio path
    // ----------------------------------------
    sample_capture sample_capture_inst (
        .clk          (clk),
        .rst          (rst),
        .mic          (mic),
        .mic_req      (mic_req),
        .mic_ack      (mic_ack),
        .sample_valid (sample_valid),
        .sample_data  (sample_data)
    );

    // One converter per band, all fed by the same strobe
    for (genvar i = 0; i < `NUM_BANDS; i++) begin : g_band
        band_converter #(
            .band_freq (band_freq_table[i])
        ) band_converter_inst (
            .clk          (clk),
            .rst          (rst),
            .sample_valid (sample_valid),
            .sample_data  (sample_data),
            .level        (levels[i])
        );
    end

    // ----------------------------------------
    // Video path
    // ----------------------------------------
    bar_renderer bar_renderer_inst (
        .clk    (clk),
        .rst    (rst),
        .x      (x),
        .y      (y),
        .levels (levels),
        .white  (white)
    );

    assign red   = {`W_COLOR{white}};   // Monochrome bars
    assign green = {`W_COLOR{white}};
    assign blue  = {`W_COLOR{white}};

endmodule

//--- spectrum_macros.svh
`ifndef SPECTRUM_MACROS_SVH
`define SPECTRUM_MACROS_SVH

// ----------------------------------------
// Screen layout
// ----------------------------------------
`define SCREEN_WIDTH    640
`define SCREEN_HEIGHT   480
`define W_COLOR         4       // Bits per colour channel

// ----------------------------------------
// Analyzer setup
// ----------------------------------------
`define NUM_BANDS       12
`define WINDOW_LEN      1024    // Accepted samples per window
`define SAMPLE_RATE_HZ  8000    // Nominal rate of the req/ack source

// Band centre frequencies in Hz, lowest band first
`define BAND_FREQ_0     132
`define BAND_FREQ_1     152
`define BAND_FREQ_2     174
`define BAND_FREQ_3     200
`define BAND_FREQ_4     230
`define BAND_FREQ_5     264
`define BAND_FREQ_6     303
`define BAND_FREQ_7     348
`define BAND_FREQ_8     400
`define BAND_FREQ_9     458
`define BAND_FREQ_10    525
`define BAND_FREQ_11    600

`endif

//--- spectrum_props.sv
`timescale 1ns/1ps

module spectrum_props (
    input logic clk,
    input logic rst,
    input logic mic_req,
    input logic mic_ack,
    input logic sample_valid,
    input logic white
);

    int error_count = 0;    // Failed properties so far

    // ----------------------------------------
    // Four-phase handshake
    // ----------------------------------------
    ack_rise_on_req: assert property (@(posedge clk) disable iff (rst)
        $rose(mic_ack) |-> $past(mic_req))
        else begin
            error_count++;
            $error("mic_ack rose without a pending mic_req");
        end

    ack_fall_after_req: assert property (@(posedge clk) disable iff (rst)
        $fell(mic_ack) |-> !$past(mic_req))
        else begin
            error_count++;
            $error("mic_ack fell while mic_req was still high");
        end

    strobe_one_cycle: assert property (@(posedge clk) disable iff (rst)
        sample_valid |=> !sample_valid)   // One strobe per accepted sample
        else begin
            error_count++;
            $error("sample_valid stayed high for more than one cycle");
        end

    // Outputs settle during the first reset cycle
    capture_idle_in_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> (!mic_ack && !sample_valid))
        else begin
            error_count++;
            $error("Capture outputs not cleared during reset");
        end

    white_low_in_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> !white)
        else begin
            error_count++;
            $error("white is high during reset");
        end

endmodule

bind spectrum spectrum_props spectrum_props_inst (
    .clk          (clk),
    .rst          (rst),
    .mic_req      (mic_req),
    .mic_ack      (mic_ack),
    .sample_valid (sample_valid),
    .white        (white)
);

//--- tb_spectrum.sv
`timescale 1ns/1ps
`include "spectrum_macros.svh"

module tb_spectrum;
    import audio_pkg::*;
    import video_pkg::*;

    localparam int clk_period      = 8;
    localparam int reset_cycles    = 4;
    localparam int ack_wait_limit  = 8;     // Cycles allowed for each ack edge
    localparam int level_latency   = 4;     // Last ack to visible bar
    localparam int handshake_count = 16;
    localparam int num_columns     = `SCREEN_WIDTH / 16;

    // Doubled budget of four cycles per sample plus four frame scans
    localparam int handshake_cycles = 4;
    localparam int scan_cycles      = num_columns * (`SCREEN_HEIGHT + 2);
    localparam int test_cycles      = (3 * `WINDOW_LEN + 64) * handshake_cycles
                                      + 4 * scan_cycles + 100;
    localparam int watchdog_cycles  = 2 * test_cycles;

    localparam color_t color_on = color_t'((1 << `W_COLOR) - 1);

    localparam int band_freq [`NUM_BANDS] = '{
        `BAND_FREQ_0, `BAND_FREQ_1, `BAND_FREQ_2,  `BAND_FREQ_3,
        `BAND_FREQ_4, `BAND_FREQ_5, `BAND_FREQ_6,  `BAND_FREQ_7,
        `BAND_FREQ_8, `BAND_FREQ_9, `BAND_FREQ_10, `BAND_FREQ_11
    };

    logic        clk;
    logic        rst;
    coord_x_t    x;
    coord_y_t    y;
    mic_sample_t mic;
    logic        mic_req;
    logic        mic_ack;
    color_t      red;
    color_t      green;
    color_t      blue;

    level_t      bar_heights [`NUM_BANDS];  // Filled by each frame scan

    spectrum spectrum_inst (
        .clk     (clk),
        .rst     (rst),
        .x       (x),
        .y       (y),
        .mic     (mic),
        .mic_req (mic_req),
        .mic_ack (mic_ack),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ----------------------------------------
    // Reporting and compare tasks
    // ----------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_color(input string name, input color_t got, input color_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0d ns: %s is %0d, expected %0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_level(input string name, input level_t got, input level_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0d ns: %s is %0d, expected %0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_ack(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0d ns: %s is %b, expected %b",
                                $time, name, got, exp));
        end
    endtask

    // Half period in samples rounded to nearest
    function automatic int half_period_of(input int freq);
        return (`SAMPLE_RATE_HZ + freq) / (2 * freq);
    endfunction

    // Owner of a column by the 3b+2 and 3b+3 rule or -1 when free
    function automatic int owner_band(input int col);
        int band;
        band = -1;
        for (int b = 0; b < `NUM_BANDS; b++) begin
            if (col == 3 * b + 2 || col == 3 * b + 3) begin
                band = b;
            end
        end
        return band;
    endfunction

    // ----------------------------------------
    // Drivers
    // ----------------------------------------
    task automatic apply_reset();
        @(posedge clk);
        rst     <= 1'b1;
        mic_req <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic send_sample(input mic_sample_t value);
        int waited;
        waited = 0;
        @(posedge clk);
        mic     <= value;
        mic_req <= 1'b1;
        @(negedge clk);
        while (!mic_ack) begin
            if (waited == ack_wait_limit) begin
                abort_run("mic_ack never rose after mic_req was raised");
            end
            @(negedge clk);
            waited++;
        end
        @(posedge clk);
        mic_req <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (mic_ack) begin
            if (waited == ack_wait_limit) begin
                abort_run("mic_ack stayed high after mic_req was dropped");
            end
            @(negedge clk);
            waited++;
        end
    endtask

    // Sweep y down one column with colour one cycle behind the coordinates
    task automatic scan_column(input int col, output level_t height);
        color_t   reds   [`SCREEN_HEIGHT];
        color_t   greens [`SCREEN_HEIGHT];
        color_t   blues  [`SCREEN_HEIGHT];
        coord_x_t x_pos;
        int       top;
        color_t   expected;
        x_pos = coord_x_t'(col * 16 + $urandom_range(15, 0));  // Any pixel of the column
        for (int row = 0; row <= `SCREEN_HEIGHT; row++) begin
            @(posedge clk);
            x <= x_pos;
            y <= coord_y_t'(row % `SCREEN_HEIGHT);
            @(negedge clk);
            if (row > 0) begin
                reds[row - 1]   = red;
                greens[row - 1] = green;
                blues[row - 1]  = blue;
            end
        end
        top = `SCREEN_HEIGHT;
        for (int row = `SCREEN_HEIGHT - 1; row >= 0; row--) begin
            if (reds[row] != '0) begin
                top = row;  // Lowest white row
            end
        end
        height = level_t'(`SCREEN_HEIGHT - top);
        for (int row = 0; row < `SCREEN_HEIGHT; row++) begin
            expected = (row >= top) ? color_on : color_t'(0);
            check_color($sformatf("red at x=%0d y=%0d", x_pos, row), reds[row], expected);
            check_color($sformatf("green at x=%0d y=%0d", x_pos, row), greens[row], expected);
            check_color($sformatf("blue at x=%0d y=%0d", x_pos, row), blues[row], expected);
        end
    endtask

    task automatic scan_frame();
        level_t height;
        int     band;
        for (int col = 0; col < num_columns; col++) begin
            scan_column(col, height);
            band = owner_band(col);
            if (band < 0) begin
                check_level($sformatf("bar height in free column %0d", col), height, 0);
            end else if (col == 3 * band + 2) begin
                bar_heights[band] = height;
            end else begin
                check_level($sformatf("bar height in second column of band %0d", band),
                            height, bar_heights[band]);
            end
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic blank_after_reset();
        @(negedge clk);
        check_ack("mic_ack after reset", mic_ack, 1'b0);
        scan_frame();
        for (int b = 0; b < `NUM_BANDS; b++) begin
            check_level($sformatf("bar height of band %0d after reset", b), bar_heights[b], 0);
        end
    endtask

    task automatic handshake_timing();
        mic_sample_t value;
        int          gap;
        for (int n = 0; n < handshake_count; n++) begin
            value = mic_sample_t'($urandom);
            gap   = $urandom_range(2, 0);
            repeat (gap) @(posedge clk);
            @(posedge clk);
            mic     <= value;
            mic_req <= 1'b1;
            @(negedge clk);
            check_ack("mic_ack before request is seen", mic_ack, 1'b0);
            @(negedge clk);
            check_ack("mic_ack one cycle after request rise", mic_ack, 1'b1);
            @(posedge clk);
            mic_req <= 1'b0;
            @(negedge clk);
            check_ack("mic_ack before release is seen", mic_ack, 1'b1);
            @(negedge clk);
            check_ack("mic_ack one cycle after request fall", mic_ack, 1'b0);
        end
    endtask

    task automatic silence_window(input string label);
        repeat (`WINDOW_LEN) send_sample(8'd128);   // Offset value is zero after centring
        repeat (level_latency) @(posedge clk);
        scan_frame();
        for (int b = 0; b < `NUM_BANDS; b++) begin
            check_level($sformatf("bar height of band %0d, %s", b, label), bar_heights[b], 0);
        end
    endtask

    task automatic tone_window(input int band);
        int          half;
        mic_sample_t value;
        half = half_period_of(band_freq[band]);
        for (int n = 0; n < `WINDOW_LEN; n++) begin
            value = ((n / half) % 2 == 0) ? 8'd255 : 8'd0;  // Full-scale square starting high
            send_sample(value);
        end
        repeat (level_latency) @(posedge clk);
        scan_frame();
        // Matched band sums about 1024 * 127.5 / 256 rows and clips
        check_level($sformatf("bar height of tone band %0d", band), bar_heights[band],
                    level_t'(`SCREEN_HEIGHT));
        for (int b = 0; b < `NUM_BANDS; b++) begin
            if (b != band && bar_heights[b] >= bar_heights[band]) begin
                abort_run($sformatf("Band %0d bar (%0d rows) is not below the tone band %0d",
                                    b, bar_heights[b], band));
            end
        end
    endtask

    // ----------------------------------------
    // Sequence and watchdog
    // ----------------------------------------
    initial begin
        int tone_band;
        void'($urandom(32'hb468));
        rst     = 1'b1;
        mic     = 8'd128;
        mic_req = 1'b0;
        x       = '0;
        y       = '0;
        apply_reset();
        blank_after_reset();
        handshake_timing();
        apply_reset();                  // Random samples left a partial window
        silence_window("silent window");
        tone_band = $urandom_range(`NUM_BANDS - 1, 0);
        tone_window(tone_band);
        silence_window("silence after the tone");
        if (spectrum_inst.spectrum_props_inst.error_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            abort_run("A bound assertion failed during the run");
        end
    end

    // Property failures from the bound checker
    initial begin
        wait (spectrum_inst.spectrum_props_inst.error_count != 0);
        abort_run("A protocol or reset assertion in spectrum_props failed");
    end

    initial begin
        #(watchdog_cycles * clk_period);
        abort_run($sformatf("Watchdog expired after %0d cycles without the tests finishing",
                            watchdog_cycles));
    end

endmodule

//--- verilog.f
+incdir+.
audio_pkg.sv
video_pkg.sv
sample_capture.sv
band_converter.sv
bar_renderer.sv
spectrum.sv
spectrum_props.sv
tb_spectrum.sv

//--- video_pkg.sv
`include "spectrum_macros.svh"

package video_pkg;

    // Pixel position from the video timing source
    typedef logic [$clog2(`SCREEN_WIDTH)-1:0]  coord_x_t;
    typedef logic [$clog2(`SCREEN_HEIGHT)-1:0] coord_y_t;

    // 16-pixel wide column, x / 16
    typedef logic [$clog2(`SCREEN_WIDTH / 16)-1:0] column_t;

    // One colour channel
    typedef logic [`W_COLOR-1:0] color_t;

endpackage
